// ==== cpu_core.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/register_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/exe_mem_wb_stage.sv
logic/cpu_core.sv
testbench/tb_apb_memory.sv
testbench/tb_cpu_core.sv

// ==== logic/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath word width
`define CPU_XLEN 16

// byte address and pc width
`define CPU_ADDR_W 32

// instruction word width
`define CPU_INST_W 32

// architectural register count
`define CPU_NUM_REGS 32

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== logic/cpu_core.sv ====
module cpu_core (
	input logic clk,
	input logic rst_i,

	output cpu_pkg::apb_req_s imem_req_o,
	input cpu_pkg::apb_rsp_s imem_rsp_i,

	output cpu_pkg::apb_req_s dmem_req_o,
	input cpu_pkg::apb_rsp_s dmem_rsp_i
);

// fetch to decode
logic fetch_valid;
cpu_pkg::inst_t fetch_inst;
cpu_pkg::addr_t fetch_pc;
logic fetch_flush;

// decode outputs
logic dec_ready;
logic dec_valid;
logic dec_jmp_valid;
cpu_pkg::addr_t dec_jmp_target;
cpu_pkg::exe_ctl_s dec_ctl;

// execute outputs
logic exe_ready;
cpu_pkg::redirect_s exe_redirect;

fetch_unit fetch (
	.clk(clk),
	.rst_i(rst_i),
	.imem_req_o(imem_req_o),
	.imem_rsp_i(imem_rsp_i),
	.ready_i(dec_ready),
	.valid_o(fetch_valid),
	.inst_o(fetch_inst),
	.pc_o(fetch_pc),
	.jmp_valid_i(dec_jmp_valid),
	.jmp_target_i(dec_jmp_target),
	.redirect_i(exe_redirect),
	.flush_o(fetch_flush)
);

decode_unit decode (
	.clk(clk),
	.rst_i(rst_i),
	.valid_i(fetch_valid),
	.ready_o(dec_ready),
	.inst_i(fetch_inst),
	.pc_i(fetch_pc),
	.flush_i(fetch_flush),
	.jmp_valid_o(dec_jmp_valid),
	.jmp_target_o(dec_jmp_target),
	.valid_o(dec_valid),
	.ctl_o(dec_ctl),
	.ready_i(exe_ready)
);

exe_mem_wb_stage exe_mem_wb (
	.clk(clk),
	.rst_i(rst_i),
	.valid_i(dec_valid),
	.ready_o(exe_ready),
	.ctl_i(dec_ctl),
	.redirect_o(exe_redirect),
	.dmem_req_o(dmem_req_o),
	.dmem_rsp_i(dmem_rsp_i)
);

endmodule

// ==== logic/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

typedef logic [`CPU_XLEN-1:0] word_t;
typedef logic [`CPU_ADDR_W-1:0] addr_t;
typedef logic [`CPU_INST_W-1:0] inst_t;
typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

// opcode sits in inst[31:28]
typedef enum logic [3:0] {
	OP_ADD = 4'h0,
	OP_SUB = 4'h1,
	OP_AND = 4'h2,
	OP_OR  = 4'h3,
	OP_XOR = 4'h4,
	OP_SHL = 4'h5,
	OP_SHR = 4'h6,
	OP_LI  = 4'h7,
	OP_LD  = 4'h8,
	OP_ST  = 4'h9,
	OP_BEQ = 4'hA,
	OP_BNE = 4'hB,
	OP_JMP = 4'hC
} op_e;

// apb master request, driven by the core
typedef struct packed {
	logic psel;
	logic penable;
	logic pwrite;
	addr_t paddr;
	logic [31:0] pwdata;
} apb_req_s;

// apb slave response
typedef struct packed {
	logic [31:0] prdata;
	logic pready;
} apb_rsp_s;

// decoded instruction handed to execute
typedef struct packed {
	op_e op;
	reg_idx_t rd;
	reg_idx_t rs;
	word_t imm;
	addr_t branch_target;
} exe_ctl_s;

// taken branch from execute back to fetch
typedef struct packed {
	logic valid;
	addr_t target;
} redirect_s;

typedef enum logic [1:0] {
	IDLE,
	SETUP,
	ACCESS
} fetch_state_e;

typedef enum logic [1:0] {
	RUN,
	MEM_SETUP,
	MEM_ACCESS
} exe_state_e;

endpackage

// ==== logic/decode_unit.sv ====
module decode_unit (
	input logic clk,
	input logic rst_i,

	input logic valid_i,
	output logic ready_o,
	input cpu_pkg::inst_t inst_i,
	input cpu_pkg::addr_t pc_i,

	input logic flush_i,

	output logic jmp_valid_o,
	output cpu_pkg::addr_t jmp_target_o,

	output logic valid_o,
	output cpu_pkg::exe_ctl_s ctl_o,
	input logic ready_i
);

cpu_pkg::exe_ctl_s ctl_d;
cpu_pkg::exe_ctl_s ctl_q;
logic valid_q;
logic accept;
logic is_jmp;
logic is_mem;

// field split of the incoming word
always_comb begin
	ctl_d.op = cpu_pkg::op_e'(inst_i[31:28]);
	ctl_d.rd = inst_i[27:23];
	ctl_d.rs = inst_i[22:18];
	ctl_d.imm = inst_i[15:0];
	// targets are absolute word indices
	ctl_d.branch_target = cpu_pkg::addr_t'({inst_i[15:0], 2'b00});
end

assign is_jmp = (ctl_d.op == cpu_pkg::OP_JMP);
assign is_mem = (ctl_d.op == cpu_pkg::OP_LD) || (ctl_d.op == cpu_pkg::OP_ST);

// the held slot frees up when execute takes it
assign ready_o = !valid_q || ready_i;
assign accept = valid_i && ready_o && !flush_i;

// jmp is resolved here and never occupies the slot
assign jmp_valid_o = accept && is_jmp;
assign jmp_target_o = ctl_d.branch_target;

always_ff @(posedge clk) begin
	if (rst_i) begin
		valid_q <= 1'b0;
	end else if (flush_i) begin
		// wrong-path entry, turn it into a bubble
		valid_q <= 1'b0;
	end else if (ready_o) begin
		valid_q <= valid_i && !is_jmp;
	end
end

always_ff @(posedge clk) begin
	if (accept && !is_jmp)
		ctl_q <= ctl_d;
end

// held entry is dead once fetch reports the flush
assign valid_o = valid_q && !flush_i;
assign ctl_o = ctl_q;

// register pairs for addressing start on an even index
a_pair_even: assert property (@(posedge clk) disable iff (rst_i)
	(accept && is_mem) |-> !ctl_d.rs[0])
	else $error("LD/ST uses odd base register %0d", ctl_d.rs);

endmodule

// ==== logic/exe_mem_wb_stage.sv ====
module exe_mem_wb_stage (
	input logic clk,
	input logic rst_i,

	input logic valid_i,
	output logic ready_o,
	input cpu_pkg::exe_ctl_s ctl_i,

	output cpu_pkg::redirect_s redirect_o,

	output cpu_pkg::apb_req_s dmem_req_o,
	input cpu_pkg::apb_rsp_s dmem_rsp_i
);

localparam int SHAMT_W = $clog2($bits(cpu_pkg::word_t));

cpu_pkg::exe_state_e state_q;
cpu_pkg::word_t rd_val;
cpu_pkg::word_t rs_val;
cpu_pkg::addr_t pair_val;
cpu_pkg::word_t alu_res;
logic accept;
logic is_wb;
logic is_mem;
logic is_branch;
logic taken;
logic shift_big;

logic redir_valid_q;
cpu_pkg::addr_t redir_target_q;
cpu_pkg::addr_t mem_addr_q;
cpu_pkg::word_t mem_wdata_q;
logic mem_write_q;
cpu_pkg::reg_idx_t mem_rd_q;

logic rf_we;
cpu_pkg::reg_idx_t rf_wa;
cpu_pkg::word_t rf_wd;

register_file regs (
	.clk(clk),
	.rst_i(rst_i),
	.ra_i(ctl_i.rd),
	.rb_i(ctl_i.rs),
	.ra_data_o(rd_val),
	.rb_data_o(rs_val),
	.pair_i(ctl_i.rs),
	.pair_data_o(pair_val),
	.we_i(rf_we),
	.wa_i(rf_wa),
	.wd_i(rf_wd)
);

// stall for the bus, and for one cycle behind a taken branch
assign ready_o = (state_q == cpu_pkg::RUN) && !redir_valid_q;
assign accept = valid_i && ready_o;

assign shift_big = (rs_val >= cpu_pkg::word_t'($bits(cpu_pkg::word_t)));
assign is_mem = (ctl_i.op == cpu_pkg::OP_LD) || (ctl_i.op == cpu_pkg::OP_ST);
assign is_branch = (ctl_i.op == cpu_pkg::OP_BEQ) || (ctl_i.op == cpu_pkg::OP_BNE);
assign taken = (ctl_i.op == cpu_pkg::OP_BEQ) ? (rd_val == rs_val) : (rd_val != rs_val);

always_comb begin
	alu_res = '0;
	is_wb = 1'b1;
	case (ctl_i.op)
		cpu_pkg::OP_ADD: alu_res = rd_val + rs_val;
		cpu_pkg::OP_SUB: alu_res = rd_val - rs_val;
		cpu_pkg::OP_AND: alu_res = rd_val & rs_val;
		cpu_pkg::OP_OR: alu_res = rd_val | rs_val;
		cpu_pkg::OP_XOR: alu_res = rd_val ^ rs_val;
		cpu_pkg::OP_SHL: alu_res = shift_big ? '0 : rd_val << rs_val[SHAMT_W-1:0];
		cpu_pkg::OP_SHR: alu_res = shift_big ? '0 : rd_val >> rs_val[SHAMT_W-1:0];
		cpu_pkg::OP_LI: alu_res = ctl_i.imm;
		default: is_wb = 1'b0;
	endcase
end

// load data takes the write port while the bus access is pending
always_comb begin
	if (state_q == cpu_pkg::MEM_ACCESS) begin
		rf_we = dmem_rsp_i.pready && !mem_write_q;
		rf_wa = mem_rd_q;
		rf_wd = cpu_pkg::word_t'(dmem_rsp_i.prdata);
	end else begin
		rf_we = accept && is_wb;
		rf_wa = ctl_i.rd;
		rf_wd = alu_res;
	end
end

always_ff @(posedge clk) begin
	if (rst_i) begin
		state_q <= cpu_pkg::RUN;
		redir_valid_q <= 1'b0;
	end else begin
		redir_valid_q <= accept && is_branch && taken;
		case (state_q)
			cpu_pkg::RUN: if (accept && is_mem) state_q <= cpu_pkg::MEM_SETUP;
			cpu_pkg::MEM_SETUP: state_q <= cpu_pkg::MEM_ACCESS;
			cpu_pkg::MEM_ACCESS: if (dmem_rsp_i.pready) state_q <= cpu_pkg::RUN;
			default: state_q <= cpu_pkg::RUN;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		redir_target_q <= ctl_i.branch_target;
		mem_addr_q <= pair_val + cpu_pkg::addr_t'(ctl_i.imm);
		mem_wdata_q <= rd_val;
		mem_write_q <= (ctl_i.op == cpu_pkg::OP_ST);
		mem_rd_q <= ctl_i.rd;
	end
end

always_comb begin
	redirect_o.valid = redir_valid_q;
	redirect_o.target = redir_target_q;
	dmem_req_o.psel = (state_q != cpu_pkg::RUN);
	dmem_req_o.penable = (state_q == cpu_pkg::MEM_ACCESS);
	dmem_req_o.pwrite = mem_write_q;
	dmem_req_o.paddr = mem_addr_q;
	dmem_req_o.pwdata = 32'(mem_wdata_q);
end

// fetch treats each redirect cycle as a new target
a_redirect_pulse: assert property (@(posedge clk) disable iff (rst_i)
	redirect_o.valid |=> !redirect_o.valid)
	else $error("redirect held longer than one cycle");

endmodule

// ==== logic/fetch_unit.sv ====
`include "cpu_config.svh"

module fetch_unit (
	input logic clk,
	input logic rst_i,

	output cpu_pkg::apb_req_s imem_req_o,
	input cpu_pkg::apb_rsp_s imem_rsp_i,

	input logic ready_i,
	output logic valid_o,
	output cpu_pkg::inst_t inst_o,
	output cpu_pkg::addr_t pc_o,

	input logic jmp_valid_i,
	input cpu_pkg::addr_t jmp_target_i,
	input cpu_pkg::redirect_s redirect_i,
	output logic flush_o
);

cpu_pkg::fetch_state_e state_q;
cpu_pkg::addr_t pc_q;
cpu_pkg::addr_t req_addr_q;
logic stale_q;
logic flush_q;
logic buf_valid_q;
cpu_pkg::inst_t buf_inst_q;
cpu_pkg::addr_t buf_pc_q;

logic redir_any;
cpu_pkg::addr_t redir_pc;
logic read_done;
logic start_ok;

// a redirect from execute is older than a jmp in decode, so it wins
always_comb begin
	redir_any = redirect_i.valid || jmp_valid_i;
	redir_pc = redirect_i.valid ? redirect_i.target : jmp_target_i;
end

assign read_done = (state_q == cpu_pkg::ACCESS) && imem_rsp_i.pready;
// only fetch when the buffer is empty or drains this cycle
assign start_ok = !buf_valid_q || ready_i;

always_ff @(posedge clk) begin
	if (rst_i) begin
		state_q <= cpu_pkg::IDLE;
		pc_q <= cpu_pkg::addr_t'(`CPU_RESET_PC);
		stale_q <= 1'b0;
		flush_q <= 1'b0;
		buf_valid_q <= 1'b0;
	end else begin
		flush_q <= redirect_i.valid;
		if (buf_valid_q && ready_i)
			buf_valid_q <= 1'b0;
		case (state_q)
			cpu_pkg::IDLE: if (!redir_any && start_ok) state_q <= cpu_pkg::SETUP;
			cpu_pkg::SETUP: state_q <= cpu_pkg::ACCESS;
			cpu_pkg::ACCESS: if (imem_rsp_i.pready) state_q <= cpu_pkg::IDLE;
			default: state_q <= cpu_pkg::IDLE;
		endcase
		if (read_done) begin
			stale_q <= 1'b0;
			if (!stale_q && !redir_any) begin
				buf_valid_q <= 1'b1;
				pc_q <= req_addr_q + cpu_pkg::addr_t'(4);
			end
		end
		if (redir_any) begin
			pc_q <= redir_pc;
			buf_valid_q <= 1'b0;
			// read still on the bus belongs to the old path
			if (state_q == cpu_pkg::SETUP || (state_q == cpu_pkg::ACCESS && !imem_rsp_i.pready))
				stale_q <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (state_q == cpu_pkg::IDLE)
		req_addr_q <= pc_q;
	if (read_done) begin
		buf_inst_q <= imem_rsp_i.prdata;
		buf_pc_q <= req_addr_q;
	end
end

always_comb begin
	imem_req_o.psel = (state_q != cpu_pkg::IDLE);
	imem_req_o.penable = (state_q == cpu_pkg::ACCESS);
	imem_req_o.pwrite = 1'b0;
	imem_req_o.paddr = req_addr_q;
	imem_req_o.pwdata = '0;
end

assign valid_o = buf_valid_q;
assign inst_o = buf_inst_q;
assign pc_o = buf_pc_q;
assign flush_o = flush_q;

// request held steady from setup through the pready cycle
a_imem_stable: assert property (@(posedge clk) disable iff (rst_i)
	(imem_req_o.psel && !(imem_req_o.penable && imem_rsp_i.pready)) |=>
	(imem_req_o.psel && imem_req_o.penable && $stable(imem_req_o.paddr)
		&& $stable(imem_req_o.pwrite)))
	else $error("imem request changed before pready");

a_imem_setup: assert property (@(posedge clk) disable iff (rst_i)
	$rose(imem_req_o.psel) |-> !imem_req_o.penable)
	else $error("imem access without setup phase");

endmodule

// ==== logic/register_file.sv ====
`include "cpu_config.svh"

module register_file (
	input logic clk,
	input logic rst_i,

	input cpu_pkg::reg_idx_t ra_i,
	input cpu_pkg::reg_idx_t rb_i,
	output cpu_pkg::word_t ra_data_o,
	output cpu_pkg::word_t rb_data_o,

	input cpu_pkg::reg_idx_t pair_i,
	output cpu_pkg::addr_t pair_data_o,

	input logic we_i,
	input cpu_pkg::reg_idx_t wa_i,
	input cpu_pkg::word_t wd_i
);

cpu_pkg::word_t regs [`CPU_NUM_REGS];
cpu_pkg::reg_idx_t pair_hi;

always_ff @(posedge clk) begin
	if (rst_i) begin
		for (int i = 0; i < `CPU_NUM_REGS; i++)
			regs[i] <= '0;
	end else if (we_i) begin
		regs[wa_i] <= wd_i;
	end
end

assign ra_data_o = regs[ra_i];
assign rb_data_o = regs[rb_i];

// odd register holds the upper half of the address
assign pair_hi = pair_i + cpu_pkg::reg_idx_t'(1);
assign pair_data_o = {regs[pair_hi], regs[pair_i]};

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs tb_cpu_core with Verilator, exits nonzero unless the run passes

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wall -Wno-fatal -f cpu_core.f --top-module tb_cpu_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_cpu_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^NO ERRORS$"; then
	exit 0
fi
exit 1

// ==== testbench/tb_apb_memory.sv ====
module tb_apb_memory #(
	parameter int ADDR_LSB = 0
) (
	input logic clk,
	input logic wait_en_i,
	input cpu_pkg::apb_req_s req_i,
	output cpu_pkg::apb_rsp_s rsp_o
);

timeunit 1ns;
timeprecision 1ps;

logic [31:0] mem [256];
logic [7:0] idx;

// index folds in every address bit above the byte or word offset
function automatic logic [7:0] word_index(input cpu_pkg::addr_t a);
	logic [31:0] w;
	w = a >> ADDR_LSB;
	return w[7:0] ^ w[15:8] ^ w[23:16] ^ w[31:24];
endfunction

// byte or word addressing, set per port
assign idx = word_index(req_i.paddr);

// every word distinct so a wrong address shows up
task automatic fill_pattern();
	for (int i = 0; i < 256; i++)
		mem[i] = {8'hC3, ~i[7:0], 8'h5A, i[7:0]};
endtask

initial begin
	rsp_o = '0;
end

// response changes on the falling edge only
always @(negedge clk) begin
	if (req_i.psel && req_i.penable) begin
		rsp_o.pready <= !wait_en_i || (($urandom % 3) != 0);
		rsp_o.prdata <= mem[idx];
	end else begin
		rsp_o <= '0;
	end
end

always @(posedge clk) begin
	if (req_i.psel && req_i.penable && rsp_o.pready && req_i.pwrite)
		mem[idx] <= req_i.pwdata;
end

endmodule

// ==== testbench/tb_cpu_core.sv ====
module tb_cpu_core;

timeunit 1ns;
timeprecision 1ps;

localparam int CLK_PERIOD = 8;
localparam int NUM_PROGS = 5;
localparam int NUM_RUNS = 2 * NUM_PROGS;

logic clk;
logic rst_i;
logic wait_en;
cpu_pkg::apb_req_s imem_req;
cpu_pkg::apb_rsp_s imem_rsp;
cpu_pkg::apb_req_s dmem_req;
cpu_pkg::apb_rsp_s dmem_rsp;

// program table
string names [NUM_PROGS];
logic [31:0] prog [NUM_PROGS][16];
int prog_n [NUM_PROGS];
logic [31:0] pre_addr [NUM_PROGS][4];
logic [15:0] pre_data [NUM_PROGS][4];
int pre_n [NUM_PROGS];
logic [31:0] exp_addr [NUM_PROGS][8];
logic [15:0] exp_data [NUM_PROGS][8];
int exp_n [NUM_PROGS];

int cur;
int seen;
int test_errs;
int pass_cnt;
int fail_cnt;

cpu_core cpu_core_i (
	.clk(clk),
	.rst_i(rst_i),
	.imem_req_o(imem_req),
	.imem_rsp_i(imem_rsp),
	.dmem_req_o(dmem_req),
	.dmem_rsp_i(dmem_rsp)
);

tb_apb_memory #(.ADDR_LSB(2)) imem (
	.clk(clk), .wait_en_i(wait_en), .req_i(imem_req), .rsp_o(imem_rsp)
);

tb_apb_memory #(.ADDR_LSB(0)) dmem (
	.clk(clk), .wait_en_i(wait_en), .req_i(dmem_req), .rsp_o(dmem_rsp)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

// append one instruction word to program t
task automatic put(input int t, input cpu_pkg::op_e op, input int rd, input int rs,
		input logic [15:0] imm);
	prog[t][prog_n[t]] = {op, rd[4:0], rs[4:0], 2'b00, imm};
	prog_n[t]++;
endtask

task automatic expect_store(input int t, input logic [31:0] addr, input logic [15:0] data);
	exp_addr[t][exp_n[t]] = addr;
	exp_data[t][exp_n[t]] = data;
	exp_n[t]++;
endtask

task automatic preset(input int t, input logic [31:0] addr, input logic [15:0] data);
	pre_addr[t][pre_n[t]] = addr;
	pre_data[t][pre_n[t]] = data;
	pre_n[t]++;
endtask

task automatic build_table();
	for (int t = 0; t < NUM_PROGS; t++) begin
		prog_n[t] = 0;
		pre_n[t] = 0;
		exp_n[t] = 0;
	end
	names[0] = "alu";
	put(0, cpu_pkg::OP_LI, 2, 0, 16'h1234);
	put(0, cpu_pkg::OP_LI, 3, 0, 16'hF00F);
	put(0, cpu_pkg::OP_ADD, 2, 3, 0);
	put(0, cpu_pkg::OP_ST, 2, 0, 16'h0010);
	put(0, cpu_pkg::OP_SUB, 2, 3, 0);
	put(0, cpu_pkg::OP_ST, 2, 0, 16'h0011);
	put(0, cpu_pkg::OP_AND, 2, 3, 0);
	put(0, cpu_pkg::OP_ST, 2, 0, 16'h0012);
	put(0, cpu_pkg::OP_XOR, 2, 3, 0);
	put(0, cpu_pkg::OP_ST, 2, 0, 16'h0013);
	put(0, cpu_pkg::OP_LI, 4, 0, 16'h0A50);
	put(0, cpu_pkg::OP_OR, 4, 3, 0);
	put(0, cpu_pkg::OP_ST, 4, 0, 16'h0014);
	put(0, cpu_pkg::OP_JMP, 0, 0, 13);
	// 0x1234 + 0xF00F wraps to 0x0243 and the sub restores 0x1234
	expect_store(0, 32'h10, 16'h0243);
	expect_store(0, 32'h11, 16'h1234);
	expect_store(0, 32'h12, 16'h1004);
	expect_store(0, 32'h13, 16'hE00B);
	expect_store(0, 32'h14, 16'hFA5F);

	names[1] = "shift";
	put(1, cpu_pkg::OP_LI, 2, 0, 16'hA5C3);
	put(1, cpu_pkg::OP_SHL, 2, 4, 0);
	put(1, cpu_pkg::OP_ST, 2, 0, 16'h0020);
	put(1, cpu_pkg::OP_LI, 4, 0, 5);
	put(1, cpu_pkg::OP_SHL, 2, 4, 0);
	put(1, cpu_pkg::OP_ST, 2, 0, 16'h0021);
	put(1, cpu_pkg::OP_LI, 4, 0, 15);
	put(1, cpu_pkg::OP_SHR, 2, 4, 0);
	put(1, cpu_pkg::OP_ST, 2, 0, 16'h0022);
	put(1, cpu_pkg::OP_LI, 4, 0, 16);
	put(1, cpu_pkg::OP_SHL, 2, 4, 0);
	put(1, cpu_pkg::OP_ST, 2, 0, 16'h0023);
	put(1, cpu_pkg::OP_LI, 4, 0, 20);
	put(1, cpu_pkg::OP_SHR, 4, 4, 0);
	put(1, cpu_pkg::OP_ST, 4, 0, 16'h0024);
	put(1, cpu_pkg::OP_JMP, 0, 0, 15);
	expect_store(1, 32'h20, 16'hA5C3);
	expect_store(1, 32'h21, 16'hB860);
	expect_store(1, 32'h22, 16'h0001);
	expect_store(1, 32'h23, 16'h0000);
	expect_store(1, 32'h24, 16'h0000);

	names[2] = "load";
	preset(2, 32'h30, 16'hBEEF);
	preset(2, 32'h35, 16'h1357);
	preset(2, 32'h0001_0042, 16'h2468);
	put(2, cpu_pkg::OP_LI, 6, 0, 16'h0030);
	put(2, cpu_pkg::OP_LD, 2, 6, 0);
	put(2, cpu_pkg::OP_LD, 3, 6, 5);
	put(2, cpu_pkg::OP_LI, 9, 0, 1);
	put(2, cpu_pkg::OP_LI, 8, 0, 16'h0040);
	put(2, cpu_pkg::OP_LD, 4, 8, 2);
	put(2, cpu_pkg::OP_ST, 2, 0, 16'h0050);
	put(2, cpu_pkg::OP_ST, 3, 0, 16'h0051);
	put(2, cpu_pkg::OP_ST, 4, 8, 16'h0010);
	put(2, cpu_pkg::OP_JMP, 0, 0, 9);
	expect_store(2, 32'h50, 16'hBEEF);
	expect_store(2, 32'h51, 16'h1357);
	// r9:r8 pair gives the upper half 0x0001
	expect_store(2, 32'h0001_0050, 16'h2468);

	names[3] = "branch";
	put(3, cpu_pkg::OP_LI, 2, 0, 7);
	put(3, cpu_pkg::OP_LI, 3, 0, 7);
	put(3, cpu_pkg::OP_LI, 4, 0, 16'h0AAA);
	put(3, cpu_pkg::OP_LI, 5, 0, 5);
	put(3, cpu_pkg::OP_BEQ, 2, 3, 6);
	put(3, cpu_pkg::OP_ST, 4, 0, 16'h0060);
	put(3, cpu_pkg::OP_ST, 4, 0, 16'h0061);
	put(3, cpu_pkg::OP_BNE, 2, 3, 9);
	put(3, cpu_pkg::OP_ST, 4, 0, 16'h0062);
	put(3, cpu_pkg::OP_BNE, 2, 5, 11);
	put(3, cpu_pkg::OP_ST, 4, 0, 16'h0063);
	put(3, cpu_pkg::OP_BEQ, 2, 5, 13);
	put(3, cpu_pkg::OP_ST, 4, 0, 16'h0064);
	put(3, cpu_pkg::OP_JMP, 0, 0, 13);
	expect_store(3, 32'h61, 16'h0AAA);
	expect_store(3, 32'h62, 16'h0AAA);
	expect_store(3, 32'h64, 16'h0AAA);

	names[4] = "jump";
	put(4, cpu_pkg::OP_LI, 2, 0, 16'h0055);
	put(4, cpu_pkg::OP_JMP, 0, 0, 3);
	put(4, cpu_pkg::OP_ST, 2, 0, 16'h0070);
	put(4, cpu_pkg::OP_ST, 2, 0, 16'h0071);
	put(4, cpu_pkg::OP_JMP, 0, 0, 4);
	expect_store(4, 32'h71, 16'h0055);
endtask

task automatic load_memories(input int t);
	imem.fill_pattern();
	dmem.fill_pattern();
	for (int i = 0; i < prog_n[t]; i++)
		imem.mem[i] = prog[t][i];
	for (int i = 0; i < pre_n[t]; i++)
		dmem.mem[dmem.word_index(pre_addr[t][i])] = {16'h0000, pre_data[t][i]};
endtask

// store checker on the completing cycle of each data write
always @(posedge clk) begin
	if (!rst_i && dmem_req.psel && dmem_req.penable && dmem_req.pwrite && dmem_rsp.pready) begin
		if (seen >= exp_n[cur]) begin
			$display("unexpected extra store to address %h at %0t", dmem_req.paddr, $time);
			test_errs++;
		end else begin
			if (dmem_req.paddr != exp_addr[cur][seen]) begin
				$display("mismatch at %0t: paddr expected %h got %h",
					$time, exp_addr[cur][seen], dmem_req.paddr);
				test_errs++;
			end
			if (dmem_req.pwdata[15:0] != exp_data[cur][seen]) begin
				$display("mismatch at %0t: pwdata expected %h got %h",
					$time, exp_data[cur][seen], dmem_req.pwdata[15:0]);
				test_errs++;
			end
		end
		seen++;
	end
end

// the instruction port only reads
always @(posedge clk) begin
	if (!rst_i && imem_req.psel && imem_req.pwrite) begin
		$display("instruction port issued a write to %h at %0t", imem_req.paddr, $time);
		test_errs++;
	end
end

initial begin
	#(NUM_RUNS * 400 * CLK_PERIOD);
	$display("timeout: the tests did not finish within %0d cycles", NUM_RUNS * 400);
	$display("ERRORS FOUND");
	$finish;
end

initial begin
	void'($urandom(70721));
	rst_i = 1'b1;
	wait_en = 1'b0;
	cur = 0;
	seen = 0;
	test_errs = 0;
	pass_cnt = 0;
	fail_cnt = 0;
	build_table();
	for (int run = 0; run < NUM_RUNS; run++) begin
		rst_i = 1'b1;
		cur = run % NUM_PROGS;
		wait_en = (run >= NUM_PROGS);
		seen = 0;
		test_errs = 0;
		load_memories(cur);
		repeat (5) @(negedge clk);
		rst_i = 1'b0;
		while (seen < exp_n[cur])
			@(negedge clk);
		// give a wrong-path store time to show up
		repeat (40) @(negedge clk);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("test %s (waits %0d): pass", names[cur], wait_en);
		end else begin
			fail_cnt++;
			$display("test %s (waits %0d): fail, %0d errors", names[cur], wait_en, test_errs);
		end
	end
	$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
	if (fail_cnt == 0) begin
		$display("NO ERRORS");
	end else begin
		$display("ERRORS FOUND");
	end
	$finish;
end

endmodule
